// File: verilog.f
+incdir+source
source/hpd_pkg.sv
source/hpd_fxarb.sv
source/hpd_onehot_mux.sv
source/hpd_core_arbiter.sv
source/hpd_mem_stage.sv
source/hpd_top.sv
test/hpd_checker.sv
test/hpd_tb.sv

// File: test/hpd_tb.sv
// Simulation top that drives random requesters into the cache front end and checks responses against a reference memory
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_tb;

    localparam int NUM_REQS   = 400;
    localparam int MAX_CYCLES = 4 * NUM_REQS;

    logic              clk_i;
    logic              rst_ni;
    logic              core_req_valid_i [`HPD_NREQ];
    logic              core_req_ready_o [`HPD_NREQ];
    hpd_pkg::hpd_req_t core_req_i       [`HPD_NREQ];
    logic              core_req_abort_i [`HPD_NREQ];
    hpd_pkg::hpd_tag_t core_req_tag_i   [`HPD_NREQ];
    hpd_pkg::hpd_pma_t core_req_pma_i   [`HPD_NREQ];
    logic              core_rsp_valid_o [`HPD_NREQ];
    hpd_pkg::hpd_rsp_t core_rsp_o       [`HPD_NREQ];

    // Reference memory and expected responses in acceptance order
    logic [`HPD_DATA_W-1:0] ref_mem [`HPD_NWORDS];
    hpd_pkg::hpd_rsp_t      exp_q [$];
    // Second-cycle fields picked with each pending request
    hpd_pkg::hpd_tag_t      pend_tag   [`HPD_NREQ];
    logic                   pend_abort [`HPD_NREQ];
    logic                   pend_unc   [`HPD_NREQ];
    logic [31:0]            lfsr_q;
    int                     issued;
    int                     accepted;
    int                     cycles;

    hpd_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch at %0t: %s expected %h got %h", $time, sig, exp, act);
        stop_run();
    endtask

    // Enabled bytes come from the store and the others keep the old word
    function automatic logic [`HPD_DATA_W-1:0] merge_bytes(input logic [`HPD_DATA_W-1:0] old_w,
                                                          input hpd_pkg::hpd_req_t req);
        logic [`HPD_DATA_W-1:0] m;
        for (int b = 0; b < `HPD_BE_W; b++) begin
            m[8*b +: 8] = {8{req.be[b]}};
        end
        return (old_w & ~m) | (req.wdata & m);
    endfunction

    task automatic new_request(input int i);
        logic [31:0]       r;
        hpd_pkg::hpd_req_t req;
        draw_bits(32, r);
        req.wdata = r;
        draw_bits(14, r);
        req.op        = r[0] ? hpd_pkg::HPD_OP_STORE : hpd_pkg::HPD_OP_LOAD;
        // Narrow address range so stored words come back often
        req.set_idx   = {1'b0, r[2:1]};
        req.be        = r[6:3];
        req.sid       = `HPD_SID_W'(i);
        req.tid       = `HPD_TID_W'(issued);
        pend_tag[i]   = r[8:7];
        pend_abort[i] = (r[11:9] == 3'b000);
        pend_unc[i]   = (r[13:12] == 2'b00);
        core_req_i[i]       <= req;
        core_req_valid_i[i] <= 1'b1;
        issued++;
    endtask

    task automatic check_responses();
        hpd_pkg::hpd_rsp_t exp;
        string             pfx;
        for (int i = 0; i < `HPD_NREQ; i++) begin
            if (core_rsp_valid_o[i] && exp_q.size() == 0) begin
                $display("response on requester %0d at %0t with nothing outstanding", i, $time);
                stop_run();
            end else if (core_rsp_valid_o[i]) begin
                exp = exp_q.pop_front();
                if (i != int'(exp.sid))
                    report_mismatch("core_rsp_valid_o index", exp.sid, i);
                // Payload is copied to every requester
                for (int j = 0; j < `HPD_NREQ; j++) begin
                    pfx = $sformatf("core_rsp_o[%0d]", j);
                    if (core_rsp_o[j].sid !== exp.sid)
                        report_mismatch({pfx, ".sid"}, exp.sid, core_rsp_o[j].sid);
                    if (core_rsp_o[j].tid !== exp.tid)
                        report_mismatch({pfx, ".tid"}, exp.tid, core_rsp_o[j].tid);
                    if (core_rsp_o[j].rdata !== exp.rdata)
                        report_mismatch({pfx, ".rdata"}, exp.rdata, core_rsp_o[j].rdata);
                    if (core_rsp_o[j].uncached !== exp.uncached)
                        report_mismatch({pfx, ".uncached"}, exp.uncached, core_rsp_o[j].uncached);
                end
            end
        end
    endtask

    // One clock of checking, acceptance bookkeeping and new input drive
    task automatic run_cycle();
        logic [31:0]            r;
        logic [`HPD_ADDR_W-1:0] addr;
        hpd_pkg::hpd_rsp_t      exp;
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d requests accepted",
                     cycles, accepted, NUM_REQS);
            stop_run();
        end else if (u_dut.u_checker.fail_cnt != 0) begin
            $display("bound checker reported an assertion failure");
            stop_run();
        end
        check_responses();
        for (int i = 0; i < `HPD_NREQ; i++) begin
            // Noise on the second-cycle lines outside the tag cycle
            draw_bits(4, r);
            core_req_tag_i[i]             <= r[1:0];
            core_req_abort_i[i]           <= r[2];
            core_req_pma_i[i].uncacheable <= r[3];
            if (core_req_valid_i[i] && core_req_ready_o[i]) begin
                accepted++;
                core_req_tag_i[i]             <= pend_tag[i];
                core_req_abort_i[i]           <= pend_abort[i];
                core_req_pma_i[i].uncacheable <= pend_unc[i];
                addr         = {pend_tag[i], core_req_i[i].set_idx};
                exp.sid      = core_req_i[i].sid;
                exp.tid      = core_req_i[i].tid;
                exp.uncached = pend_unc[i];
                exp.rdata    = (core_req_i[i].op == hpd_pkg::HPD_OP_STORE) ? '0 : ref_mem[addr];
                // Aborted requests leave memory and response queue alone
                if (!pend_abort[i]) begin
                    if (core_req_i[i].op == hpd_pkg::HPD_OP_STORE)
                        ref_mem[addr] = merge_bytes(ref_mem[addr], core_req_i[i]);
                    exp_q.push_back(exp);
                end
            end
            if (!core_req_valid_i[i] || core_req_ready_o[i]) begin
                draw_bits(2, r);
                if (issued < NUM_REQS && r[1:0] != 2'b00) begin
                    new_request(i);
                end else begin
                    core_req_valid_i[i] <= 1'b0;
                end
            end
        end
    endtask

    initial begin
        lfsr_q   = 32'h6a62_171c;
        issued   = 0;
        accepted = 0;
        cycles   = 0;
        rst_ni   = 1'b0;
        for (int i = 0; i < `HPD_NREQ; i++) begin
            core_req_valid_i[i] = 1'b0;
            core_req_i[i]       = '0;
            core_req_abort_i[i] = 1'b0;
            core_req_tag_i[i]   = '0;
            core_req_pma_i[i]   = '0;
        end
        for (int w = 0; w < `HPD_NWORDS; w++) begin
            ref_mem[w] = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        while (accepted < NUM_REQS || exp_q.size() != 0) begin
            @(posedge clk_i);
            run_cycle();
        end
        // Idle tail catches late or stray responses
        repeat (4) begin
            @(posedge clk_i);
            run_cycle();
        end
        #1;
        if (u_dut.u_checker.fail_cnt != 0) begin
            $display("bound checker reported an assertion failure at the end of the run");
            stop_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: test/hpd_checker.sv
// Assertions bound into the front end top: priority, store slot, grant hold and response routing
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_checker (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              req_valid_i [`HPD_NREQ],
    input logic              req_ready_i [`HPD_NREQ],
    input hpd_pkg::hpd_req_t req_i       [`HPD_NREQ],
    input logic              req_abort_i [`HPD_NREQ],
    input logic              rsp_valid_i [`HPD_NREQ],
    input hpd_pkg::hpd_rsp_t rsp_i       [`HPD_NREQ],
    input logic              arb_valid_i,
    input logic              arb_ready_i
);

    // Failed assertions so far, polled by the testbench
    int unsigned fail_cnt = 0;

    logic [`HPD_NREQ-1:0] valid_v;
    logic [`HPD_NREQ-1:0] ready_v;
    logic [`HPD_NREQ-1:0] rsp_v;
    logic [`HPD_NREQ-1:0] acc_store_v;
    logic                 stall;

    always_comb begin
        for (int i = 0; i < `HPD_NREQ; i++) begin
            valid_v[i]     = req_valid_i[i];
            ready_v[i]     = req_ready_i[i];
            rsp_v[i]       = rsp_valid_i[i];
            acc_store_v[i] = req_valid_i[i] && req_ready_i[i]
                             && (req_i[i].op == hpd_pkg::HPD_OP_STORE);
        end
    end

    // Memory stage refuses the granted request
    assign stall = arb_valid_i && !arb_ready_i;

    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(ready_v))
    else begin
        $error("more than one requester sees ready");
        fail_cnt++;
    end

    // Write slot of a store takes no request
    a_store_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        |acc_store_v |=> ready_v == '0)
    else begin
        $error("ready high in the write slot of a store");
        fail_cnt++;
    end

    for (genvar i = 0; i < `HPD_NREQ; i++) begin : g_req
        // Some lower-index requester is asking
        logic lower_valid;
        assign lower_valid = |(valid_v & ((`HPD_NREQ'(1) << i) - `HPD_NREQ'(1)));

        // Skipping a lower requester is only allowed for a grant held through a stall
        a_priority: assert property (@(posedge clk_i) disable iff (!rst_ni)
            ready_v[i] && lower_valid |-> $past(stall && valid_v[i] && !lower_valid))
        else begin
            $error("requester %0d got ready over a lower-index request", i);
            fail_cnt++;
        end

        // Stalled owner is served next, no matter who arrives
        a_keep_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
            stall && valid_v[i] && !lower_valid |=> ready_v[i])
        else begin
            $error("requester %0d lost its grant after a stall", i);
            fail_cnt++;
        end

        // Two cycles on, one response to the owner unless aborted, same tid
        a_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
            valid_v[i] && ready_v[i] |-> ##2
                (rsp_v == (`HPD_NREQ'(!$past(req_abort_i[i])) << i))
                && (!rsp_v[i] || rsp_i[i].tid == $past(req_i[i].tid, 2)))
        else begin
            $error("wrong response valid or tid for requester %0d", i);
            fail_cnt++;
        end
    end

endmodule

bind hpd_top hpd_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (core_req_valid_i),
    .req_ready_i (core_req_ready_o),
    .req_i       (core_req_i),
    .req_abort_i (core_req_abort_i),
    .rsp_valid_i (core_rsp_valid_o),
    .rsp_i       (core_rsp_o),
    .arb_valid_i (arb_req_valid),
    .arb_ready_i (arb_req_ready)
);

// File: source/hpd_top.sv
// Top of the cache request front end, arbiter stage wired to the memory stage
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_top (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Requester side, first cycle
    input  logic              core_req_valid_i [`HPD_NREQ],
    output logic              core_req_ready_o [`HPD_NREQ],
    input  hpd_pkg::hpd_req_t core_req_i       [`HPD_NREQ],

    // Requester side, second cycle
    input  logic              core_req_abort_i [`HPD_NREQ],
    input  hpd_pkg::hpd_tag_t core_req_tag_i   [`HPD_NREQ],
    input  hpd_pkg::hpd_pma_t core_req_pma_i   [`HPD_NREQ],

    // Responses per requester
    output logic              core_rsp_valid_o [`HPD_NREQ],
    output hpd_pkg::hpd_rsp_t core_rsp_o       [`HPD_NREQ]
);

    // Arbiter to memory stage
    logic              arb_req_valid;
    logic              arb_req_ready;
    hpd_pkg::hpd_req_t arb_req;
    logic              arb_abort;
    hpd_pkg::hpd_tag_t arb_tag;
    hpd_pkg::hpd_pma_t arb_pma;

    // Memory stage back to the demux
    logic              rsp_valid;
    hpd_pkg::hpd_rsp_t rsp;

    hpd_core_arbiter u_core_arbiter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .core_req_ready_o (core_req_ready_o),
        .core_req_i       (core_req_i),
        .core_req_abort_i (core_req_abort_i),
        .core_req_tag_i   (core_req_tag_i),
        .core_req_pma_i   (core_req_pma_i),
        .rsp_valid_i      (rsp_valid),
        .rsp_i            (rsp),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .arb_req_valid_o  (arb_req_valid),
        .arb_req_ready_i  (arb_req_ready),
        .arb_req_o        (arb_req),
        .arb_abort_o      (arb_abort),
        .arb_tag_o        (arb_tag),
        .arb_pma_o        (arb_pma)
    );

    hpd_mem_stage u_mem_stage (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (arb_req_valid),
        .req_ready_o (arb_req_ready),
        .req_i       (arb_req),
        .abort_i     (arb_abort),
        .tag_i       (arb_tag),
        .pma_i       (arb_pma),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

endmodule

// File: source/hpd_mem_stage.sv
// Memory stages: latch the request, join the tag, access the word array and return the response
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_mem_stage (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Request from the arbiter
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  hpd_pkg::hpd_req_t req_i,

    // Second-cycle fields, valid the cycle after acceptance
    input  logic              abort_i,
    input  hpd_pkg::hpd_tag_t tag_i,
    input  hpd_pkg::hpd_pma_t pma_i,

    // Registered response
    output logic              rsp_valid_o,
    output hpd_pkg::hpd_rsp_t rsp_o
);

    // Word array, single port
    logic [`HPD_DATA_W-1:0] mem_q [`HPD_NWORDS];

    // Stage 1, accepted request waiting for its tag
    logic                   s1_valid_q;
    hpd_pkg::hpd_req_t      s1_req_q;

    // Full address and data path in the tag cycle
    logic                   s1_go;
    logic                   s1_store;
    logic [`HPD_ADDR_W-1:0] s1_addr;
    logic [`HPD_DATA_W-1:0] s1_rword;
    logic [`HPD_DATA_W-1:0] s1_merged;

    // Pending write, lands one cycle after the read
    logic                   wr_en_q;
    logic [`HPD_ADDR_W-1:0] wr_addr_q;
    logic [`HPD_DATA_W-1:0] wr_data_q;

    // Response register
    logic                   rsp_valid_q;
    hpd_pkg::hpd_rsp_t      rsp_q;

    // Store in stage 1 blocks the next slot, the port writes then
    assign s1_store    = s1_valid_q && (s1_req_q.op == hpd_pkg::HPD_OP_STORE);
    assign req_ready_o = !s1_store;

    // Stage 1 control
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid_i && req_ready_o;
        end
    end

    // Request payload, loaded only on acceptance
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            s1_req_q <= req_i;
        end
    end

    // Tag cycle: join address and read the old word
    assign s1_go    = s1_valid_q && !abort_i;
    assign s1_addr  = {tag_i, s1_req_q.set_idx};
    assign s1_rword = mem_q[s1_addr];

    // Byte merge for stores
    always_comb begin
        for (int b = 0; b < `HPD_BE_W; b++) begin
            if (s1_req_q.be[b]) begin
                s1_merged[8*b +: 8] = s1_req_q.wdata[8*b +: 8];
            end else begin
                s1_merged[8*b +: 8] = s1_rword[8*b +: 8];
            end
        end
    end

    // Stage 2 control, aborted requests vanish here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
            wr_en_q     <= 1'b0;
        end else begin
            rsp_valid_q <= s1_go;
            wr_en_q     <= s1_go && s1_store;
        end
    end

    // Stage 2 payload
    always_ff @(posedge clk_i) begin
        wr_addr_q      <= s1_addr;
        wr_data_q      <= s1_merged;
        // Store answers with zero data
        rsp_q.rdata    <= s1_store ? '0 : s1_rword;
        rsp_q.sid      <= s1_req_q.sid;
        rsp_q.tid      <= s1_req_q.tid;
        rsp_q.uncached <= pma_i.uncacheable;
    end

    // Array write in the store's write slot
    // Contents start from zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < `HPD_NWORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (wr_en_q) begin
            mem_q[wr_addr_q] <= wr_data_q;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

// File: source/hpd_core_arbiter.sv
// Request stage: picks one requester per cycle, aligns its tag cycle and routes responses back
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_core_arbiter (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Requester side, first cycle
    input  logic              core_req_valid_i [`HPD_NREQ],
    output logic              core_req_ready_o [`HPD_NREQ],
    input  hpd_pkg::hpd_req_t core_req_i       [`HPD_NREQ],

    // Requester side, second cycle
    input  logic              core_req_abort_i [`HPD_NREQ],
    input  hpd_pkg::hpd_tag_t core_req_tag_i   [`HPD_NREQ],
    input  hpd_pkg::hpd_pma_t core_req_pma_i   [`HPD_NREQ],

    // Response from the memory stage
    input  logic              rsp_valid_i,
    input  hpd_pkg::hpd_rsp_t rsp_i,

    // Responses per requester
    output logic              core_rsp_valid_o [`HPD_NREQ],
    output hpd_pkg::hpd_rsp_t core_rsp_o       [`HPD_NREQ],

    // Granted request toward the memory stage
    output logic              arb_req_valid_o,
    input  logic              arb_req_ready_i,
    output hpd_pkg::hpd_req_t arb_req_o,
    output logic              arb_abort_o,
    output hpd_pkg::hpd_tag_t arb_tag_o,
    output hpd_pkg::hpd_pma_t arb_pma_o
);

    // Valids and aborts packed for the arbiter and the OR
    logic [`HPD_NREQ-1:0] req_valid;
    logic [`HPD_NREQ-1:0] req_abort;

    // Live grant, changes with the request vector
    logic [`HPD_NREQ-1:0] arb_gnt;
    // Grant of the request accepted last cycle
    logic [`HPD_NREQ-1:0] arb_gnt_q;

    // Pack valid and abort, drive per-requester ready
    always_comb begin
        for (int i = 0; i < `HPD_NREQ; i++) begin
            req_valid[i]        = core_req_valid_i[i];
            req_abort[i]        = core_req_abort_i[i];
            // Ready only for the granted requester, and only if downstream takes it
            core_req_ready_o[i] = arb_gnt[i] & arb_req_ready_i;
        end
    end

    // Fixed priority, grant held on stall
    hpd_fxarb u_fxarb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (req_valid),
        .ready_i (arb_req_ready_i),
        .gnt_o   (arb_gnt)
    );

    assign arb_req_valid_o = |arb_gnt;

    // First-cycle request follows the live grant
    hpd_onehot_mux #(
        .payload_t (hpd_pkg::hpd_req_t),
        .N         (`HPD_NREQ)
    ) u_req_mux (
        .sel_i  (arb_gnt),
        .data_i (core_req_i),
        .data_o (arb_req_o)
    );

    // Grant at acceptance, selects the tag cycle one clock later
    // Zero when nothing was accepted, so tag, PMA and abort read as zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_gnt_q <= '0;
        end else begin
            arb_gnt_q <= arb_gnt & {`HPD_NREQ{arb_req_ready_i}};
        end
    end

    // Tag of the accepted requester
    hpd_onehot_mux #(
        .payload_t (hpd_pkg::hpd_tag_t),
        .N         (`HPD_NREQ)
    ) u_tag_mux (
        .sel_i  (arb_gnt_q),
        .data_i (core_req_tag_i),
        .data_o (arb_tag_o)
    );

    // Page attribute of the accepted requester
    hpd_onehot_mux #(
        .payload_t (hpd_pkg::hpd_pma_t),
        .N         (`HPD_NREQ)
    ) u_pma_mux (
        .sel_i  (arb_gnt_q),
        .data_i (core_req_pma_i),
        .data_o (arb_pma_o)
    );

    // Single-bit abort, plain AND-OR under the registered grant
    assign arb_abort_o = |(req_abort & arb_gnt_q);

    // Response demux by source id
    // Payload goes to everyone, valid only to the owner
    always_comb begin
        for (int i = 0; i < `HPD_NREQ; i++) begin
            core_rsp_valid_o[i] = rsp_valid_i && (int'(rsp_i.sid) == i);
            core_rsp_o[i]       = rsp_i;
        end
    end

endmodule

// File: source/hpd_onehot_mux.sv
// AND-OR multiplexer with one-hot select, shared by request, tag and attribute paths
`timescale 1ns/1ps

module hpd_onehot_mux #(
    parameter type payload_t = logic,
    parameter int  N         = 2
) (
    input  logic [N-1:0] sel_i,
    input  payload_t     data_i [N],
    output payload_t     data_o
);

    localparam int W = $bits(payload_t);

    // Flat accumulator, payload may be a struct
    logic [W-1:0] acc;

    always_comb begin
        acc = '0;
        for (int i = 0; i < N; i++) begin
            // Mask each input with its own select bit
            acc = acc | (W'(data_i[i]) & {W{sel_i[i]}});
        end
    end

    // Zero selected gives zero payload
    assign data_o = payload_t'(acc);

endmodule

// File: source/hpd_fxarb.sv
// Fixed-priority arbiter with grant hold under back-pressure, used by the request stage
`timescale 1ns/1ps
`include "hpd_consts.svh"

module hpd_fxarb (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`HPD_NREQ-1:0]  req_i,
    input  logic                  ready_i,
    output logic [`HPD_NREQ-1:0]  gnt_o
);

    // Lowest set bit of the request vector
    logic [`HPD_NREQ-1:0] pri_gnt;
    // Grant that was stalled in the previous cycle
    logic [`HPD_NREQ-1:0] gnt_q;
    // Stalled requester still asking
    logic                 hold;

    // Two's complement trick isolates the lowest-index request
    assign pri_gnt = req_i & (~req_i + `HPD_NREQ'(1));

    // Keep the stalled grant as long as its owner keeps valid high
    assign hold = |(gnt_q & req_i);

    always_comb begin
        if (hold) begin
            gnt_o = gnt_q;
        end else begin
            gnt_o = pri_gnt;
        end
    end

    // Remember the grant only when downstream refused it
    // An accepted grant clears the hold
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_q <= '0;
        end else if (ready_i) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= gnt_o;
        end
    end

endmodule

// File: source/hpd_pkg.sv
// Request, response and page attribute types shared by the cache front end and its testbench
`include "hpd_consts.svh"

package hpd_pkg;

    // Operation carried in the first request cycle
    typedef enum logic {
        HPD_OP_LOAD  = 1'b0,
        HPD_OP_STORE = 1'b1
    } hpd_op_e;

    // First-cycle request
    // Tag arrives one cycle later, so only the set index is here
    typedef struct packed {
        hpd_op_e                 op;
        logic [`HPD_SET_W-1:0]   set_idx;
        logic [`HPD_BE_W-1:0]    be;
        logic [`HPD_DATA_W-1:0]  wdata;
        logic [`HPD_SID_W-1:0]   sid;
        logic [`HPD_TID_W-1:0]   tid;
    } hpd_req_t;

    // Second-cycle tag
    typedef logic [`HPD_TAG_W-1:0] hpd_tag_t;

    // Page attribute, second cycle
    typedef struct packed {
        logic uncacheable;
    } hpd_pma_t;

    // Response back to the requester
    // Routed by sid, matched by tid
    typedef struct packed {
        logic [`HPD_DATA_W-1:0]  rdata;
        logic [`HPD_SID_W-1:0]   sid;
        logic [`HPD_TID_W-1:0]   tid;
        logic                    uncached;
    } hpd_rsp_t;

endpackage

// File: source/hpd_consts.svh
// Width and count constants for the cache request front end, included by package and RTL
`ifndef HPD_CONSTS_SVH
`define HPD_CONSTS_SVH

// Number of requesters on the arbiter
`define HPD_NREQ 3

// Address split, tag on top of set index
`define HPD_SET_W 3
`define HPD_TAG_W 2
`define HPD_ADDR_W (`HPD_TAG_W + `HPD_SET_W)
`define HPD_NWORDS (1 << `HPD_ADDR_W)

// Data word and its byte enables
`define HPD_DATA_W 32
`define HPD_BE_W (`HPD_DATA_W / 8)

// Transaction and source ids
`define HPD_TID_W 4
`define HPD_SID_W 2

`endif
